// File: include/dcache_defines.svh
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// Processor word and cache line geometry
`define DC_XLEN       32         // Processor word width
`define DC_LINE_BITS  128        // One cache line, four words
`define DC_WORDS      4          // Words per line

// Set organization
`define DC_WAYS       4          // Ways per set
`define DC_SETS       16         // Number of sets

// Address field widths
`define DC_WAY_W      2          // Way number
`define DC_IDX_W      4          // Set index
`define DC_OFS_W      2          // Word offset inside a line

// Tag is what is left above index, offset and the two byte bits
`define DC_TAG_W      (`DC_XLEN - `DC_IDX_W - `DC_OFS_W - 2)

`endif

// File: source/dcache_pkg.sv
`include "dcache_defines.svh"

package dcache_pkg;

    //==========================================================================
    // Basic data types
    //==========================================================================
    typedef logic [`DC_XLEN-1:0]      word_t;   // One processor word
    typedef logic [`DC_LINE_BITS-1:0] line_t;   // One cache line, word 0 at MSB
    typedef logic [`DC_TAG_W-1:0]     tag_t;    // Tag field
    typedef logic [`DC_WAY_W-1:0]     way_t;    // Way number
    typedef logic [`DC_IDX_W-1:0]     idx_t;    // Set index

    // Processor address seen as one word or as its cache fields
    typedef union packed
    {
        word_t flat;                            // Whole byte address
        struct packed
        {
            tag_t                 tag;          // Compared against stored tags
            idx_t                 idx;          // Selects the set
            logic [`DC_OFS_W-1:0] ofs;          // Word inside the line
            logic [1:0]           bsel;         // Byte inside the word
        } f;
    } addr_u;

    //==========================================================================
    // Controller states
    //==========================================================================
    typedef enum logic [2:0]
    {
        INIT,           // Clearing valid and dirty bits, one set per cycle
        IDLE,           // Waiting for a processor strobe
        LOOKUP,         // Tag compare on the registered request
        WB_REQ,         // Dirty victim going out to memory
        WB_DONE,        // Write-back acknowledged
        FILL_REQ,       // Line read from memory
        FILL_DONE       // Fill written into the victim way
    } dc_state_e;

endpackage

// File: source/dcache_store_if.sv
`timescale 1ns/1ns
`include "dcache_defines.svh"

// Set storage port, driven by the controller and answered by the ways
interface dcache_store_if
    import dcache_pkg::*;
();
    // Controller side
    idx_t                index;         // Set read and written this cycle
    tag_t                wr_tag;        // Tag stored with the line
    line_t               wr_line;       // Line data to store
    logic [`DC_WAYS-1:0] data_we;       // Tag and data write, per way
    logic [`DC_WAYS-1:0] valid_we;
    logic                valid_d;
    logic [`DC_WAYS-1:0] dirty_we;
    logic                dirty_d;
    logic                init_clear;    // Zero valid and dirty of the whole set
    way_t                sel_way;       // Way read out for eviction

    // Storage side, all from the index of the previous edge
    logic                hit;
    way_t                hit_way;
    line_t               hit_line;
    line_t               sel_line;
    tag_t                sel_tag;
    logic                sel_dirty;

    modport ctrl (output index, wr_tag, wr_line, data_we, valid_we, valid_d,
                         dirty_we, dirty_d, init_clear, sel_way,
                  input  hit, hit_way, hit_line, sel_line, sel_tag, sel_dirty);

    modport store (input  index, wr_tag, wr_line, data_we, valid_we, valid_d,
                          dirty_we, dirty_d, init_clear, sel_way,
                   output hit, hit_way, hit_line, sel_line, sel_tag, sel_dirty);

endinterface

// File: source/dcache_ways.sv
`timescale 1ns/1ns
`include "dcache_defines.svh"

module dcache_ways
    import dcache_pkg::*;
(
    input  logic          clk_i,
    input  logic          rst_i,
    dcache_store_if.store st_i,
    input  tag_t          lookup_tag_i      // Registered request tag
);

    //==========================================================================
    // Storage arrays
    //==========================================================================
    tag_t                tag_mem   [`DC_WAYS][`DC_SETS];
    line_t               data_mem  [`DC_WAYS][`DC_SETS];
    logic [`DC_WAYS-1:0] valid_mem [`DC_SETS];              // One bit per way
    logic [`DC_WAYS-1:0] dirty_mem [`DC_SETS];

    idx_t                idx_q;                             // Read address register
    logic [`DC_WAYS-1:0] way_hit;
    way_t                hit_way;

    // Tag and line are always written as a pair
    always_ff @(posedge clk_i)
    begin
        for (int w = 0; w < `DC_WAYS; w++)
        begin
            if (st_i.data_we[w])
            begin
                tag_mem[w][st_i.index]  <= st_i.wr_tag;
                data_mem[w][st_i.index] <= st_i.wr_line;
            end
        end
    end

    // Status bits, init clears every way of one set at once
    always_ff @(posedge clk_i)
    begin
        if (st_i.init_clear)
        begin
            valid_mem[st_i.index] <= '0;
            dirty_mem[st_i.index] <= '0;
        end
        else
        begin
            for (int w = 0; w < `DC_WAYS; w++)
            begin
                if (st_i.valid_we[w])
                    valid_mem[st_i.index][w] <= st_i.valid_d;
                if (st_i.dirty_we[w])
                    dirty_mem[st_i.index][w] <= st_i.dirty_d;
            end
        end
    end

    // Synchronous read, results follow the index of the last edge
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            idx_q <= '0;
        else
            idx_q <= st_i.index;
    end

    //==========================================================================
    // Hit detection
    //==========================================================================
    always_comb
    begin
        way_hit = '0;
        hit_way = '0;
        for (int w = 0; w < `DC_WAYS; w++)
            way_hit[w] = valid_mem[idx_q][w] && (tag_mem[w][idx_q] == lookup_tag_i);
        // At most one way matches, lowest wins otherwise
        for (int w = `DC_WAYS-1; w >= 0; w--)
            if (way_hit[w])
                hit_way = way_t'(w);
    end

    assign st_i.hit      = |way_hit;
    assign st_i.hit_way  = hit_way;
    assign st_i.hit_line = data_mem[hit_way][idx_q];

    // Victim readout for the write-back path
    assign st_i.sel_line  = data_mem[st_i.sel_way][idx_q];
    assign st_i.sel_tag   = tag_mem[st_i.sel_way][idx_q];
    assign st_i.sel_dirty = dirty_mem[idx_q][st_i.sel_way];

endmodule

// File: source/dcache_merge.sv
`timescale 1ns/1ns
`include "dcache_defines.svh"

module dcache_merge
    import dcache_pkg::*;
(
    input  line_t                  src_line_i,     // Hit line or fill line
    input  logic [`DC_OFS_W-1:0]   ofs_i,          // Word offset of the request
    input  logic [`DC_XLEN/8-1:0]  be_i,           // Byte enables, bit 0 is [7:0]
    input  word_t                  wdata_i,        // Store data
    output word_t                  rd_word_o,      // Addressed word, unmodified
    output line_t                  merged_line_o   // Line with the store applied
);

    word_t cur_word;
    word_t new_word;

    // Word 0 sits in the top 32 bits of the line
    always_comb
    begin
        cur_word = '0;
        for (int w = 0; w < `DC_WORDS; w++)
            if (ofs_i == `DC_OFS_W'(w))
                cur_word = src_line_i[(`DC_WORDS-1-w)*`DC_XLEN +: `DC_XLEN];
    end

    assign rd_word_o = cur_word;

    // Any byte pattern, each lane taken from store data when enabled
    always_comb
    begin
        new_word = cur_word;
        for (int b = 0; b < `DC_XLEN/8; b++)
            if (be_i[b])
                new_word[8*b +: 8] = wdata_i[8*b +: 8];
    end

    //==========================================================================
    // Put the word back into its slot
    //==========================================================================
    always_comb
    begin
        merged_line_o = src_line_i;
        for (int w = 0; w < `DC_WORDS; w++)
            if (ofs_i == `DC_OFS_W'(w))
                merged_line_o[(`DC_WORDS-1-w)*`DC_XLEN +: `DC_XLEN] = new_word;
    end

endmodule

// File: source/dcache_ctrl.sv
`timescale 1ns/1ns
`include "dcache_defines.svh"

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_i,
    // Processor side
    input  logic                   p_strobe_i,
    input  logic                   p_rw_i,          // 1 for store
    input  logic [`DC_XLEN/8-1:0]  p_byte_enable_i,
    input  addr_u                  p_addr_i,
    input  word_t                  p_data_i,
    output word_t                  p_data_o,
    output logic                   p_ready_o,
    // Memory side
    output logic                   m_strobe_o,      // One-cycle request pulse
    output addr_u                  m_addr_o,        // Always line aligned
    output logic                   m_rw_o,
    input  line_t                  m_data_i,
    output line_t                  m_data_o,
    input  logic                   m_ready_i,
    // Storage and merge unit
    dcache_store_if.ctrl           st_o,
    output tag_t                   lookup_tag_o,
    output line_t                  src_line_o,
    output logic [`DC_OFS_W-1:0]   ofs_o,
    output logic [`DC_XLEN/8-1:0]  be_o,
    output word_t                  wdata_o,
    input  word_t                  rd_word_i,
    input  line_t                  merged_line_i
);

    dc_state_e             state_q, state_d;
    idx_t                  init_cnt;                // Set being cleared in INIT
    addr_u                 req_addr;                // Request held for the whole access
    logic                  req_rw;
    logic [`DC_XLEN/8-1:0] req_be;
    word_t                 req_wdata;
    line_t                 fill_q;                  // Line returned by memory
    way_t                  fifo_q [`DC_SETS];       // Next victim per set
    way_t                  victim;
    addr_u                 fill_addr, wb_addr;
    logic                  mem_req, mem_req_q;
    logic                  ready;

    assign victim = fifo_q[req_addr.f.idx];

    //==========================================================================
    // State machine
    //==========================================================================
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            state_q <= INIT;
        else
            state_q <= state_d;
    end

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            INIT:      if (init_cnt == idx_t'(`DC_SETS-1)) state_d = IDLE;
            IDLE:      if (p_strobe_i) state_d = LOOKUP;
            LOOKUP:
            begin
                if (!st_o.hit)
                    state_d = st_o.sel_dirty ? WB_REQ : FILL_REQ;   // Dirty victim first
                else
                    state_d = IDLE;
            end
            WB_REQ:    if (m_ready_i) state_d = WB_DONE;
            WB_DONE:   state_d = FILL_REQ;
            FILL_REQ:  if (m_ready_i) state_d = FILL_DONE;
            FILL_DONE: state_d = IDLE;
            default:   state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            init_cnt <= '0;
        else if (state_q == INIT)
            init_cnt <= init_cnt + 1'b1;   // Wraps back to 0 on the way out
    end

    // Request capture, payload only
    always_ff @(posedge clk_i)
    begin
        if (state_q == IDLE && p_strobe_i)
        begin
            req_addr  <= p_addr_i;
            req_rw    <= p_rw_i;
            req_be    <= p_byte_enable_i;
            req_wdata <= p_data_i;
        end
        if (state_q == FILL_REQ && m_ready_i)
            fill_q <= m_data_i;
    end

    // FIFO replacement, advance once the victim way has been refilled
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            for (int s = 0; s < `DC_SETS; s++)
                fifo_q[s] <= '0;
        end
        else if (state_q == FILL_DONE)
            fifo_q[req_addr.f.idx] <= victim + 1'b1;
    end

    //==========================================================================
    // Storage control
    //==========================================================================
    always_comb
    begin
        st_o.index      = req_addr.f.idx;
        st_o.wr_tag     = req_addr.f.tag;
        st_o.wr_line    = (state_q == FILL_DONE && !req_rw) ? fill_q : merged_line_i;
        st_o.data_we    = '0;
        st_o.valid_we   = '0;
        st_o.valid_d    = 1'b1;                // Only fills touch valid
        st_o.dirty_we   = '0;
        st_o.dirty_d    = req_rw;              // Stores set, read fills clear
        st_o.init_clear = 1'b0;
        st_o.sel_way    = victim;
        case (state_q)
            INIT:
            begin
                st_o.index      = init_cnt;
                st_o.init_clear = 1'b1;
            end
            IDLE:
                if (p_strobe_i)
                    st_o.index = p_addr_i.f.idx;   // Live index so LOOKUP sees it
            LOOKUP:
            begin
                if (st_o.hit && req_rw)
                begin
                    st_o.data_we  = `DC_WAYS'(1) << st_o.hit_way;   // Write hit
                    st_o.dirty_we = `DC_WAYS'(1) << st_o.hit_way;
                end
            end
            FILL_DONE:
            begin
                st_o.data_we  = `DC_WAYS'(1) << victim;
                st_o.valid_we = `DC_WAYS'(1) << victim;
                st_o.dirty_we = `DC_WAYS'(1) << victim;
            end
            default: ;
        endcase
    end

    assign lookup_tag_o = req_addr.f.tag;
    assign src_line_o   = (state_q == FILL_DONE) ? fill_q : st_o.hit_line;
    assign ofs_o        = req_addr.f.ofs;
    assign be_o         = req_be;
    assign wdata_o      = req_wdata;

    // Processor response
    assign ready     = (state_q == LOOKUP && st_o.hit) || (state_q == FILL_DONE);
    assign p_ready_o = ready;
    assign p_data_o  = (ready && !req_rw) ? rd_word_i : '0;

    //==========================================================================
    // Memory requests
    //==========================================================================
    always_comb
    begin
        fill_addr        = req_addr;
        fill_addr.f.ofs  = '0;                 // Line aligned
        fill_addr.f.bsel = '0;
        wb_addr          = fill_addr;
        wb_addr.f.tag    = st_o.sel_tag;       // Victim line, same set
    end

    assign mem_req = (state_q == WB_REQ || state_q == FILL_REQ) && !m_ready_i;

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            mem_req_q  <= 1'b0;
            m_strobe_o <= 1'b0;
        end
        else
        begin
            mem_req_q  <= mem_req;
            m_strobe_o <= mem_req && !mem_req_q;   // Rising edge only
        end
    end

    // Address and direction hold steady through the request
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            m_addr_o.flat <= '0;
            m_rw_o        <= 1'b0;
        end
        else if (state_q == WB_REQ)
        begin
            m_addr_o <= wb_addr;
            m_rw_o   <= 1'b1;
        end
        else if (state_q == FILL_REQ)
        begin
            m_addr_o <= fill_addr;
            m_rw_o   <= 1'b0;
        end
        else
        begin
            m_addr_o.flat <= '0;
            m_rw_o        <= 1'b0;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (state_q == WB_REQ)
            m_data_o <= st_o.sel_line;         // Victim line
    end

endmodule

// File: source/dcache_top.sv
`timescale 1ns/1ns
`include "dcache_defines.svh"

module dcache_top
    import dcache_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      rst_i,
    // Processor side
    input  logic                      p_strobe_i,
    input  logic                      p_rw_i,
    input  logic [`DC_XLEN/8-1:0]     p_byte_enable_i,
    input  logic [`DC_XLEN-1:0]       p_addr_i,
    input  logic [`DC_XLEN-1:0]       p_data_i,
    output logic [`DC_XLEN-1:0]       p_data_o,
    output logic                      p_ready_o,
    // Memory side
    output logic                      m_strobe_o,
    output logic [`DC_XLEN-1:0]       m_addr_o,
    output logic                      m_rw_o,
    input  logic [`DC_LINE_BITS-1:0]  m_data_i,
    output logic [`DC_LINE_BITS-1:0]  m_data_o,
    input  logic                      m_ready_i
);

    dcache_store_if st ();

    tag_t                  lookup_tag;
    line_t                 src_line;
    logic [`DC_OFS_W-1:0]  ofs;
    logic [`DC_XLEN/8-1:0] be;
    word_t                 wdata;
    word_t                 rd_word;
    line_t                 merged_line;

    // Controller, address ports carry the union view
    dcache_ctrl u_ctrl (
        .clk_i(clk_i), .rst_i(rst_i),
        .p_strobe_i(p_strobe_i), .p_rw_i(p_rw_i), .p_byte_enable_i(p_byte_enable_i),
        .p_addr_i(p_addr_i), .p_data_i(p_data_i), .p_data_o(p_data_o),
        .p_ready_o(p_ready_o),
        .m_strobe_o(m_strobe_o), .m_addr_o(m_addr_o), .m_rw_o(m_rw_o),
        .m_data_i(m_data_i), .m_data_o(m_data_o), .m_ready_i(m_ready_i),
        .st_o(st.ctrl), .lookup_tag_o(lookup_tag),
        .src_line_o(src_line), .ofs_o(ofs), .be_o(be), .wdata_o(wdata),
        .rd_word_i(rd_word), .merged_line_i(merged_line)
    );

    dcache_ways u_ways (.clk_i(clk_i), .rst_i(rst_i), .st_i(st.store),
                        .lookup_tag_i(lookup_tag));

    dcache_merge u_merge (.src_line_i(src_line), .ofs_i(ofs), .be_i(be), .wdata_i(wdata),
                          .rd_word_o(rd_word), .merged_line_o(merged_line));

endmodule

// File: verif/tb_mem_model.sv
`timescale 1ns/1ns
`include "dcache_defines.svh"

// Line-wide main memory, one request at a time
module tb_mem_model
    import dcache_pkg::*;
#(
    parameter int SEED = 32'h8046
)
(
    input  logic  clk_i,
    input  logic  rst_i,
    input  logic  strobe_i,        // One-cycle request pulse
    input  word_t addr_i,          // Line aligned
    input  logic  rw_i,            // 1 for a write-back
    input  line_t wdata_i,
    output line_t rdata_o,
    output logic  ready_o
);

    word_t  mem [word_t];          // Written words only
    integer seed;
    int     wait_cyc;
    word_t  req_addr;
    logic   req_rw;
    line_t  req_line;

    // Unwritten words follow their address
    function automatic word_t mem_rd(input word_t a);
        if (mem.exists(a))
            return mem[a];
        return a ^ 32'hA5A50000;
    endfunction

    initial
    begin
        seed    = SEED;
        ready_o = 1'b0;
        rdata_o = '0;
        forever
        begin
            @(negedge clk_i);                               // Mid-cycle, request is stable
            if (!rst_i && strobe_i)
            begin
                req_addr = addr_i;
                req_rw   = rw_i;
                req_line = wdata_i;
                wait_cyc = 1 + ($unsigned($random(seed)) % 6);  // 1 to 6 cycles
                repeat (wait_cyc) @(posedge clk_i);
                #1;
                for (int w = 0; w < `DC_WORDS; w++)
                begin
                    if (req_rw)
                        mem[req_addr + 4*w] = req_line[(`DC_WORDS-1-w)*32 +: 32];
                    else
                        rdata_o[(`DC_WORDS-1-w)*32 +: 32] = mem_rd(req_addr + 4*w);
                end
                ready_o = 1'b1;                             // Single-cycle answer
                @(posedge clk_i);
                #1;
                ready_o = 1'b0;
                rdata_o = '0;
            end
        end
    end

endmodule

// File: verif/tb_dcache.sv
`timescale 1ns/1ns
`include "dcache_defines.svh"

module tb_dcache
    import dcache_pkg::*;
();

    logic        clk_i = 1'b0;
    logic        rst_i = 1'b1;
    logic        p_strobe_i;
    logic        p_rw_i;
    logic [3:0]  p_byte_enable_i;
    word_t       p_addr_i;
    word_t       p_data_i;
    word_t       p_data_o;
    logic        p_ready_o;
    logic        m_strobe_o;
    logic        m_rw_o;
    logic        m_ready_i;
    word_t       m_addr_o;
    line_t       m_data_i;
    line_t       m_data_o;

    integer      seed = 32'h8046;
    int          val_err = 0;
    int          proto_err = 0;
    int          to_cnt = 0;
    logic        timed_out = 1'b0;      // Later requests are skipped once set
    logic        mem_busy;
    int          seq = 0;               // Memory requests seen so far
    int          wr_cnt = 0;
    int          rd_cnt = 0;
    int          wr_seq = 0;
    int          rd_seq = 0;
    word_t       wr_addr;               // Last write-back address
    word_t       rd_addr;               // Last fill address
    word_t       shadow [word_t];       // Processor view of memory, written words only

    always #2 clk_i = ~clk_i;           // 4 ns period

    dcache_top uut (
        .clk_i(clk_i), .rst_i(rst_i),
        .p_strobe_i(p_strobe_i), .p_rw_i(p_rw_i), .p_byte_enable_i(p_byte_enable_i),
        .p_addr_i(p_addr_i), .p_data_i(p_data_i), .p_data_o(p_data_o), .p_ready_o(p_ready_o),
        .m_strobe_o(m_strobe_o), .m_addr_o(m_addr_o), .m_rw_o(m_rw_o),
        .m_data_i(m_data_i), .m_data_o(m_data_o), .m_ready_i(m_ready_i)
    );

    tb_mem_model u_mem (.clk_i(clk_i), .rst_i(rst_i), .strobe_i(m_strobe_o), .addr_i(m_addr_o),
                        .rw_i(m_rw_o), .wdata_i(m_data_o), .rdata_o(m_data_i),
                        .ready_o(m_ready_i));

    //==========================================================================
    // Shadow memory and helpers
    //==========================================================================
    function automatic word_t shadow_rd(input word_t a);
        word_t wa;
        wa = {a[31:2], 2'b00};
        if (shadow.exists(wa))
            return shadow[wa];
        return wa ^ 32'hA5A50000;                       // Same rule as the memory model
    endfunction

    function automatic line_t shadow_line(input word_t la);
        line_t l;
        for (int w = 0; w < `DC_WORDS; w++)
            l[(`DC_WORDS-1-w)*32 +: 32] = shadow_rd(la + 4*w);   // Word 0 at the top
        return l;
    endfunction

    task automatic shadow_wr(input word_t a, input logic [3:0] be, input word_t d);
        word_t v;
        v = shadow_rd(a);
        for (int b = 0; b < 4; b++)
            if (be[b])
                v[8*b +: 8] = d[8*b +: 8];
        shadow[{a[31:2], 2'b00}] = v;
    endtask

    function automatic word_t make_addr(input tag_t tag, input idx_t idx, input logic [1:0] ofs);
        return {tag, idx, ofs, 2'b00};
    endfunction

    task automatic flag_mismatch(input string name, input line_t exp, input line_t got);
        val_err++;
        $display("[FAIL] %s exp 0x%0h got 0x%0h", name, exp, got);
    endtask

    // One processor request, lat counts cycles from the strobe to p_ready_o
    task automatic access(input logic rw, input word_t addr, input logic [3:0] be,
                          input word_t wdata, output int lat);
        word_t exp;
        int    cnt;
        logic  got;
        lat = 0;
        if (timed_out)
            return;
        exp = shadow_rd(addr);
        @(posedge clk_i);
        #1;
        p_strobe_i      = 1'b1;
        p_rw_i          = rw;
        p_byte_enable_i = be;
        p_addr_i        = addr;
        p_data_i        = wdata;
        @(posedge clk_i);
        #1;
        p_strobe_i = 1'b0;
        cnt = 0;
        got = 1'b0;
        while (!got && cnt < 200)
        begin
            @(negedge clk_i);                           // Outputs settled mid-cycle
            cnt++;
            got = p_ready_o;
        end
        if (!got)
        begin
            to_cnt++;
            timed_out = 1'b1;
            $display("No p_ready_o within 200 cycles for address %h", addr);
        end
        else
        begin
            lat = cnt;
            if (rw)
                shadow_wr(addr, be, wdata);
            else
                assert (p_data_o == exp) else flag_mismatch("p_data_o", exp, p_data_o);
        end
    endtask

    //==========================================================================
    // Memory bus monitor and protocol checks
    //==========================================================================
    always @(posedge clk_i)
    begin
        if (rst_i)
            mem_busy <= 1'b0;
        else if (m_strobe_o)
            mem_busy <= 1'b1;
        else if (m_ready_i)
            mem_busy <= 1'b0;
    end

    always @(negedge clk_i)
    begin
        if (!rst_i && m_strobe_o)
        begin
            seq++;
            if (m_rw_o)
            begin
                wr_cnt++;
                wr_seq  = seq;
                wr_addr = m_addr_o;
                assert (m_data_o == shadow_line(m_addr_o))  // Victim must hold processor view
                else flag_mismatch("m_data_o", shadow_line(m_addr_o), m_data_o);
            end
            else
            begin
                rd_cnt++;
                rd_seq  = seq;
                rd_addr = m_addr_o;
            end
        end
    end

    pulse_once: assert property (@(posedge clk_i) disable iff (rst_i) m_strobe_o |=> !m_strobe_o)
    else
    begin
        proto_err++;
        $display("m_strobe_o stayed high for two cycles");
    end

    line_align: assert property (@(posedge clk_i) disable iff (rst_i)
                                 (m_strobe_o || mem_busy) |-> m_addr_o[3:0] == 4'h0)
    else flag_mismatch("m_addr_o[3:0]", 0, $sampled(m_addr_o[3:0]));

    // Store responses carry no data either
    data_quiet: assert property (@(posedge clk_i) disable iff (rst_i)
                                 (!p_ready_o || p_rw_i) |-> p_data_o == '0)
    else flag_mismatch("p_data_o", 0, $sampled(p_data_o));

    reset_quiet: assert property (@(posedge clk_i)
                                  rst_i |=> !p_ready_o && !m_strobe_o && !m_rw_o && m_addr_o == '0)
    else
    begin
        proto_err++;
        $display("Outputs not idle during reset");
    end

    //==========================================================================
    // Stimulus
    //==========================================================================
    initial
    begin
        word_t addr;
        word_t rnd;
        word_t la [5];
        int    lat;
        int    n_wr;
        int    n_rd;
        p_strobe_i      = 1'b0;
        p_rw_i          = 1'b0;
        p_byte_enable_i = 4'h0;
        p_addr_i        = '0;
        p_data_i        = '0;
        repeat (16) @(posedge clk_i);
        #1 rst_i = 1'b0;
        repeat (`DC_SETS + 2) @(posedge clk_i);         // Let INIT sweep all sets

        // Random mix over sets 0 to 3, six tags force evictions and write-backs
        for (int i = 0; i < 64; i++)
        begin
            rnd  = $random(seed);
            addr = make_addr(24'h40 + 24'(rnd[10:8] % 6), {2'b00, rnd[5:4]}, rnd[3:2]);
            if (rnd[0])
            begin
                access(1'b1, addr, rnd[15:12], $random(seed), lat);
                access(1'b0, addr, 4'h0, '0, lat);      // Read back the merged word
            end
            else
                access(1'b0, addr, 4'h0, '0, lat);
        end

        // Write miss allocates, then a write hit on the same word
        addr = make_addr(24'h300, 4'd5, 2'd2);
        access(1'b1, addr, 4'b1001, $random(seed), lat);
        access(1'b0, addr, 4'h0, '0, lat);
        access(1'b1, addr, 4'b0110, $random(seed), lat);
        access(1'b0, addr, 4'h0, '0, lat);

        // Repeat read of a freshly filled line is a one-cycle hit
        addr = make_addr(24'h310, 4'd6, 2'd1);
        access(1'b0, addr, 4'h0, '0, lat);
        n_rd = seq;
        access(1'b0, addr, 4'h0, '0, lat);
        assert (lat == 1) else flag_mismatch("p_ready_o latency", 1, lat);
        assert (seq == n_rd) else
        begin
            proto_err++;
            $display("Memory request issued on a read hit");
        end

        // FIFO order in set 9, first tag is dirty when it gets evicted
        for (int k = 0; k < 5; k++)
            la[k] = make_addr(24'h200 + 24'(k), 4'd9, 2'd0);
        access(1'b0, la[0], 4'h0, '0, lat);
        access(1'b1, la[0] + 4, 4'b0110, $random(seed), lat);
        for (int k = 1; k < 4; k++)
            access(1'b0, la[k], 4'h0, '0, lat);
        n_wr = wr_cnt;
        access(1'b0, la[4], 4'h0, '0, lat);
        assert (wr_cnt == n_wr + 1) else
        begin
            proto_err++;
            $display("Dirty victim was not written back exactly once");
        end
        assert (wr_addr == la[0]) else flag_mismatch("m_addr_o write-back", la[0], wr_addr);
        assert (rd_addr == la[4]) else flag_mismatch("m_addr_o fill", la[4], rd_addr);
        assert (wr_seq < rd_seq) else
        begin
            proto_err++;
            $display("Fill request came before the write-back");
        end

        // Evicted tag misses again, victim is now a clean line
        n_wr = wr_cnt;
        n_rd = rd_cnt;
        access(1'b0, la[0] + 4, 4'h0, '0, lat);
        assert (lat > 1 && rd_cnt == n_rd + 1) else
        begin
            proto_err++;
            $display("First tag filled still hits after five fills");
        end
        assert (rd_addr == la[0]) else flag_mismatch("m_addr_o refill", la[0], rd_addr);
        assert (wr_cnt == n_wr) else
        begin
            proto_err++;
            $display("Clean victim was written back");
        end

        repeat (4) @(posedge clk_i);
        $display("Errors: %0d value, %0d protocol, %0d timeout", val_err, proto_err, to_cnt);
        if (val_err + proto_err + to_cnt == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+include
source/dcache_pkg.sv
source/dcache_store_if.sv
source/dcache_ways.sv
source/dcache_merge.sv
source/dcache_ctrl.sv
source/dcache_top.sv
verif/tb_mem_model.sv
verif/tb_dcache.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_dcache
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
PASS_MSG  = All tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
